// ==== cart_mem_ctrl.f ====
rtl/cart_pkg.sv
rtl/snes_bus_sync.sv
rtl/snes_alive_monitor.sv
rtl/mcu_request_router.sv
rtl/rom_cycle_ctrl.sv
rtl/ram_cycle_ctrl.sv
rtl/cart_mem_ctrl.sv
testbench/cart_mem_ctrl_tb.sv

// ==== rtl/cart_mem_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_mem_ctrl #(
  parameter int unsigned ROM_CYCLE_LEN = 7,
  parameter int unsigned RAM_CYCLE_LEN = 5,
  parameter int unsigned DEAD_TIMEOUT  = 84000   // about 1 ms of CLK2
) (
  input  wire                       CLK2,
  input  wire                       reset,
  // console pins
  input  wire                       snes_cpu_clk,
  input  wire                       snes_romsel_n,
  input  wire cart_pkg::mcu_addr_t  snes_addr_in,
  // MCU
  input  wire                       mcu_rrq,
  input  wire                       mcu_wrq,
  input  wire cart_pkg::mcu_addr_t  mcu_addr,
  input  wire cart_pkg::byte_t      mcu_dout,
  output cart_pkg::byte_t           mcu_din,
  output logic                      mcu_rdy,
  output logic                      snes_reset_strobe,
  // ROM bus
  output cart_pkg::rom_addr_t       rom_addr,
  input  wire cart_pkg::rom_word_t  rom_data_in,
  output cart_pkg::rom_word_t       rom_data_out,
  output logic                      rom_data_oe,
  output logic                      rom_we,
  output logic                      rom_bhe,
  output logic                      rom_ble,
  // RAM bus
  output cart_pkg::ram_addr_t       ram_addr,
  input  wire cart_pkg::byte_t      ram_data_in,
  output cart_pkg::byte_t           ram_data_out,
  output logic                      ram_data_oe,
  output logic                      ram_we
);
  import cart_pkg::*;

  mcu_addr_t snes_addr;
  logic      snes_romsel, cpu_clk_high, cycle_start, cycle_end;
  logic      snes_dead, restart;
  logic      rom_rrq, rom_wrq, ram_rrq, ram_wrq;
  logic      rom_rdy, ram_rdy, rom_rd_done, ram_rd_done;
  byte_t     rom_rd_data, ram_rd_data;

  snes_bus_sync u_sync (
    .CLK2(CLK2), .reset(reset), .cpu_clk_pin(snes_cpu_clk), .romsel_pin(snes_romsel_n),
    .addr_pin(snes_addr_in), .snes_addr(snes_addr), .snes_romsel(snes_romsel),
    .cpu_clk_high(cpu_clk_high), .cycle_start(cycle_start), .cycle_end(cycle_end)
  );

  snes_alive_monitor #(.DEAD_TIMEOUT(DEAD_TIMEOUT)) u_alive (
    .CLK2(CLK2), .reset(reset), .cpu_clk_high(cpu_clk_high), .snes_dead(snes_dead),
    .snes_reset_strobe(snes_reset_strobe), .restart(restart)
  );

  mcu_request_router u_router (
    .CLK2(CLK2), .reset(reset), .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_addr(mcu_addr),
    .mcu_din(mcu_din), .mcu_rdy(mcu_rdy), .rom_rrq(rom_rrq), .rom_wrq(rom_wrq),
    .ram_rrq(ram_rrq), .ram_wrq(ram_wrq), .rom_rdy(rom_rdy), .ram_rdy(ram_rdy),
    .rom_rd_done(rom_rd_done), .rom_rd_data(rom_rd_data),
    .ram_rd_done(ram_rd_done), .ram_rd_data(ram_rd_data)
  );

  rom_cycle_ctrl #(.ROM_CYCLE_LEN(ROM_CYCLE_LEN)) u_rom (
    .CLK2(CLK2), .reset(reset), .restart(restart), .rrq(rom_rrq), .wrq(rom_wrq),
    .addr(mcu_addr), .wdata(mcu_dout), .rdy(rom_rdy), .rd_done(rom_rd_done),
    .rd_data(rom_rd_data), .rom_addr(rom_addr), .rom_data_in(rom_data_in),
    .rom_data_out(rom_data_out), .rom_data_oe(rom_data_oe), .rom_we(rom_we),
    .rom_bhe(rom_bhe), .rom_ble(rom_ble)
  );

  ram_cycle_ctrl #(.RAM_CYCLE_LEN(RAM_CYCLE_LEN)) u_ram (
    .CLK2(CLK2), .reset(reset), .restart(restart), .snes_dead(snes_dead),
    .cycle_start(cycle_start), .cycle_end(cycle_end), .snes_romsel(snes_romsel),
    .snes_addr(snes_addr), .rrq(ram_rrq), .wrq(ram_wrq), .addr(mcu_addr), .wdata(mcu_dout),
    .rdy(ram_rdy), .rd_done(ram_rd_done), .rd_data(ram_rd_data), .ram_addr(ram_addr),
    .ram_data_in(ram_data_in), .ram_data_out(ram_data_out), .ram_data_oe(ram_data_oe),
    .ram_we(ram_we)
  );

endmodule : cart_mem_ctrl

`default_nettype wire

// ==== rtl/cart_pkg.sv ====
`default_nettype none

package cart_pkg;

  // bus widths
  typedef logic [23:0] mcu_addr_t;   // MCU and console byte address
  typedef logic [22:0] rom_addr_t;   // ROM word address, byte address >> 1
  typedef logic [18:0] ram_addr_t;   // 512 KiB RAM byte address
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;

  // ----------------------------------------------------------------------
  // RAM window 0x880000..0x8FFFFF
  // ----------------------------------------------------------------------
  // addr[23:19] == 5'b10001 covers exactly 0x88..0x8F in the bank byte
  localparam logic [4:0] RAM_WINDOW_TAG = 5'b10001;

endpackage : cart_pkg

`default_nettype wire

// ==== rtl/mcu_request_router.sv ====
`timescale 1ns/1ps
`default_nettype none

module mcu_request_router (
  input  wire                       CLK2,
  input  wire                       reset,
  input  wire                       mcu_rrq,
  input  wire                       mcu_wrq,
  input  wire cart_pkg::mcu_addr_t  mcu_addr,
  output cart_pkg::byte_t           mcu_din,
  output logic                      mcu_rdy,
  output logic                      rom_rrq,
  output logic                      rom_wrq,
  output logic                      ram_rrq,
  output logic                      ram_wrq,
  input  wire                       rom_rdy,
  input  wire                       ram_rdy,
  input  wire                       rom_rd_done,
  input  wire cart_pkg::byte_t      rom_rd_data,
  input  wire                       ram_rd_done,
  input  wire cart_pkg::byte_t      ram_rd_data
);
  import cart_pkg::*;

  logic ram_hit;

  // ----------------------------------------------------------------------
  // region decode
  // ----------------------------------------------------------------------
  assign ram_hit = (mcu_addr[23:19] == RAM_WINDOW_TAG);

  assign rom_rrq = mcu_rrq & ~ram_hit;
  assign rom_wrq = mcu_wrq & ~ram_hit;
  assign ram_rrq = mcu_rrq & ram_hit;
  assign ram_wrq = mcu_wrq & ram_hit;

  // busy while either bus holds the request
  assign mcu_rdy = rom_rdy & ram_rdy;

  // ----------------------------------------------------------------------
  // read data capture
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (reset) begin
      mcu_din <= '0;
    end else if (rom_rd_done) begin
      mcu_din <= rom_rd_data;
    end else if (ram_rd_done) begin
      mcu_din <= ram_rd_data;
    end
  end

endmodule : mcu_request_router

`default_nettype wire

// ==== rtl/ram_cycle_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ram_cycle_ctrl #(
  parameter int unsigned RAM_CYCLE_LEN = 5
) (
  input  wire                       CLK2,
  input  wire                       reset,
  input  wire                       restart,
  input  wire                       snes_dead,
  input  wire                       cycle_start,
  input  wire                       cycle_end,
  input  wire                       snes_romsel,
  input  wire cart_pkg::mcu_addr_t  snes_addr,
  input  wire                       rrq,
  input  wire                       wrq,
  input  wire cart_pkg::mcu_addr_t  addr,
  input  wire cart_pkg::byte_t      wdata,
  output logic                      rdy,
  output logic                      rd_done,
  output cart_pkg::byte_t           rd_data,
  output cart_pkg::ram_addr_t       ram_addr,
  input  wire cart_pkg::byte_t      ram_data_in,
  output cart_pkg::byte_t           ram_data_out,
  output logic                      ram_data_oe,
  output logic                      ram_we
);
  import cart_pkg::*;

  localparam int DLY_W = $clog2(RAM_CYCLE_LEN + 2);

  typedef enum logic [1:0] {IDLE, RD_ADDR, WR_ADDR, END} state_t;

  state_t           state;
  logic [DLY_W-1:0] delay_cnt;
  logic             rd_pend;
  logic             wr_pend;
  logic             free_strobe;
  logic             free_slot;
  ram_addr_t        addr_r;
  byte_t            wdata_r;

  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end else if (rrq || wrq) begin
      rd_pend <= rrq;
      wr_pend <= wrq & ~rrq;
      rdy     <= 1'b0;
    end else if (state == END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (rrq || wrq) begin
      addr_r  <= addr[18:0];
      wdata_r <= wdata;
    end
  end

  // ----------------------------------------------------------------------
  // free slot on console cycle end or on a cycle that skips ROM
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (reset) free_strobe <= 1'b0;
    else free_strobe <= cycle_start & snes_romsel;   // romsel high means no ROM hit
  end

  assign free_slot = cycle_end | free_strobe;

  always_ff @(posedge CLK2) begin
    if (reset || restart) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          delay_cnt <= DLY_W'(RAM_CYCLE_LEN);
          if (free_slot || snes_dead) begin
            if (rd_pend) state <= RD_ADDR;
            else if (wr_pend) state <= WR_ADDR;
          end
        end
        RD_ADDR, WR_ADDR: begin
          delay_cnt <= delay_cnt - DLY_W'(1);
          if (delay_cnt == '0) state <= END;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge CLK2) begin
    if (state == RD_ADDR) rd_data <= ram_data_in;
  end

  assign rd_done      = (state == END) & rd_pend;
  assign ram_addr     = (state != IDLE) ? addr_r : snes_addr[18:0];   // console owns the bus otherwise
  assign ram_data_out = wdata_r;
  assign ram_data_oe  = (state != IDLE) & wr_pend;
  assign ram_we       = ~(state == WR_ADDR);

endmodule : ram_cycle_ctrl

`default_nettype wire

// ==== rtl/rom_cycle_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rom_cycle_ctrl #(
  parameter int unsigned ROM_CYCLE_LEN = 7
) (
  input  wire                       CLK2,
  input  wire                       reset,
  input  wire                       restart,
  input  wire                       rrq,
  input  wire                       wrq,
  input  wire cart_pkg::mcu_addr_t  addr,
  input  wire cart_pkg::byte_t      wdata,
  output logic                      rdy,
  output logic                      rd_done,
  output cart_pkg::byte_t           rd_data,
  output cart_pkg::rom_addr_t       rom_addr,
  input  wire cart_pkg::rom_word_t  rom_data_in,
  output cart_pkg::rom_word_t       rom_data_out,
  output logic                      rom_data_oe,
  output logic                      rom_we,
  output logic                      rom_bhe,
  output logic                      rom_ble
);
  import cart_pkg::*;

  localparam int DLY_W = $clog2(ROM_CYCLE_LEN + 2);

  typedef enum logic [1:0] {IDLE, RD_ADDR, WR_ADDR, END} state_t;

  state_t           state;
  logic [DLY_W-1:0] delay_cnt;
  logic             rd_pend;
  logic             wr_pend;
  logic             active;
  mcu_addr_t        addr_r;
  byte_t            wdata_r;

  // ----------------------------------------------------------------------
  // request latch
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (reset) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end else if (rrq) begin
      rd_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (wrq) begin
      wr_pend <= 1'b1;
      rdy     <= 1'b0;
    end else if (state == END) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      rdy     <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (rrq || wrq) begin
      addr_r <= addr;
    end
    if (wrq) begin
      wdata_r <= wdata;
    end
  end

  // ----------------------------------------------------------------------
  // cycle FSM starts as soon as a request is pending
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK2) begin
    if (reset || restart) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          delay_cnt <= DLY_W'(ROM_CYCLE_LEN);
          if (rd_pend) state <= RD_ADDR;
          else if (wr_pend) state <= WR_ADDR;
        end
        RD_ADDR, WR_ADDR: begin
          delay_cnt <= delay_cnt - DLY_W'(1);
          if (delay_cnt == '0) state <= END;
        end
        default: state <= IDLE;   // END
      endcase
    end
  end

  // odd byte on the low lane, even byte on the high lane
  always_ff @(posedge CLK2) begin
    if (state == RD_ADDR) begin
      rd_data <= addr_r[0] ? rom_data_in[7:0] : rom_data_in[15:8];
    end
  end

  assign active  = (state != IDLE);
  assign rd_done = (state == END) & rd_pend;

  assign rom_addr     = addr_r[23:1];
  assign rom_data_out = addr_r[0] ? {8'h00, wdata_r} : {wdata_r, 8'h00};
  assign rom_data_oe  = active & wr_pend;   // held through END for hold time
  assign rom_we       = ~(state == WR_ADDR);
  assign rom_bhe      = ~(active & ~addr_r[0]);
  assign rom_ble      = ~(active & addr_r[0]);

endmodule : rom_cycle_ctrl

`default_nettype wire

// ==== rtl/snes_alive_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_alive_monitor #(
  parameter int unsigned DEAD_TIMEOUT = 84000
) (
  input  wire  CLK2,
  input  wire  reset,
  input  wire  cpu_clk_high,
  output logic snes_dead,
  output logic snes_reset_strobe,
  output logic restart
);

  // counter saturates one past the timeout
  localparam int CNT_W = $clog2(DEAD_TIMEOUT + 2);
  localparam logic [CNT_W-1:0] TIMEOUT_CNT = CNT_W'(DEAD_TIMEOUT);

  logic [CNT_W-1:0] low_cnt;

  always_ff @(posedge CLK2) begin
    if (reset || cpu_clk_high) begin
      low_cnt <= '0;
    end else if (low_cnt <= TIMEOUT_CNT) begin
      low_cnt <= low_cnt + CNT_W'(1);
    end
  end

  always_ff @(posedge CLK2) begin
    if (reset) begin
      snes_dead         <= 1'b1;   // wait for a clock before trusting the console
      snes_reset_strobe <= 1'b0;
    end else begin
      snes_reset_strobe <= 1'b0;
      if (cpu_clk_high) begin
        snes_dead         <= 1'b0;
        snes_reset_strobe <= snes_dead;   // console just came back
      end else if (low_cnt > TIMEOUT_CNT) begin
        snes_dead <= 1'b1;
      end
    end
  end

  // abort and rerun any access begun while the console was gone
  assign restart = snes_dead & cpu_clk_high;

endmodule : snes_alive_monitor

`default_nettype wire

// ==== rtl/snes_bus_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module snes_bus_sync (
  input  wire                       CLK2,
  input  wire                       reset,
  input  wire                       cpu_clk_pin,
  input  wire                       romsel_pin,
  input  wire cart_pkg::mcu_addr_t  addr_pin,
  output cart_pkg::mcu_addr_t       snes_addr,
  output logic                      snes_romsel,
  output logic                      cpu_clk_high,
  output logic                      cycle_start,
  output logic                      cycle_end
);
  import cart_pkg::*;

  logic [7:0] cpu_clk_sr;   // bit 0 is the newest sample
  logic [7:0] romsel_sr;
  mcu_addr_t  addr_dly [7];

  always_ff @(posedge CLK2) begin
    if (reset) begin
      cpu_clk_sr <= '0;   // console treated as stopped
      romsel_sr  <= '1;   // no ROM select
    end else begin
      cpu_clk_sr <= {cpu_clk_sr[6:0], cpu_clk_pin};
      romsel_sr  <= {romsel_sr[6:0], romsel_pin};
    end
  end

  // address delay line
  always_ff @(posedge CLK2) begin
    addr_dly[0] <= addr_pin;
    for (int i = 1; i < 7; i++) begin
      addr_dly[i] <= addr_dly[i-1];
    end
  end

  // glitch filter on two adjacent taps
  assign snes_addr    = addr_dly[6] & addr_dly[5];
  assign snes_romsel  = romsel_sr[7] & romsel_sr[6];
  assign cpu_clk_high = cpu_clk_sr[1];

  // edge after five stable samples of the other level
  assign cycle_start = (cpu_clk_sr[7:2] == 6'b000001);
  assign cycle_end   = (cpu_clk_sr[7:2] == 6'b111110);

endmodule : snes_bus_sync

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --timescale 1ns/1ps --top-module cart_mem_ctrl_tb \
  -f cart_mem_ctrl.f -Mdir obj_dir

sim_out=$(./obj_dir/Vcart_mem_ctrl_tb 2>&1 || true)
echo "$sim_out"

if grep -qx "TEST OK" <<< "$sim_out"; then
  exit 0
fi
exit 1

// ==== testbench/cart_mem_ctrl_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cart_mem_ctrl_tb;
  import cart_pkg::*;

  localparam int MAX_CYCLES = 20000;   // about 2.5x the expected run length

  logic      CLK2;
  logic      reset;
  logic      snes_cpu_clk;
  logic      snes_romsel_n;
  mcu_addr_t snes_addr_in;
  logic      mcu_rrq;
  logic      mcu_wrq;
  mcu_addr_t mcu_addr;
  byte_t     mcu_dout;
  byte_t     mcu_din;
  logic      mcu_rdy;
  logic      snes_reset_strobe;
  rom_addr_t rom_addr;
  rom_word_t rom_data_in;
  rom_word_t rom_data_out;
  logic      rom_data_oe;
  logic      rom_we;
  logic      rom_bhe;
  logic      rom_ble;
  ram_addr_t ram_addr;
  byte_t     ram_data_in;
  byte_t     ram_data_out;
  logic      ram_data_oe;
  logic      ram_we;

  byte_t     rom_mem [mcu_addr_t];   // keyed by byte address
  byte_t     ram_mem [ram_addr_t];
  byte_t     ref_mem [mcu_addr_t];   // expected contents by MCU address
  mcu_addr_t written [$];
  mcu_addr_t cur_addr;
  logic      console_run;
  int        strobe_cnt;
  int        strobe_base;
  int        cycle_cnt;

  cart_mem_ctrl #(.DEAD_TIMEOUT(200)) cart_mem_ctrl_i (
    .CLK2(CLK2), .reset(reset), .snes_cpu_clk(snes_cpu_clk), .snes_romsel_n(snes_romsel_n),
    .snes_addr_in(snes_addr_in), .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_addr(mcu_addr),
    .mcu_dout(mcu_dout), .mcu_din(mcu_din), .mcu_rdy(mcu_rdy),
    .snes_reset_strobe(snes_reset_strobe), .rom_addr(rom_addr), .rom_data_in(rom_data_in),
    .rom_data_out(rom_data_out), .rom_data_oe(rom_data_oe), .rom_we(rom_we),
    .rom_bhe(rom_bhe), .rom_ble(rom_ble), .ram_addr(ram_addr), .ram_data_in(ram_data_in),
    .ram_data_out(ram_data_out), .ram_data_oe(ram_data_oe), .ram_we(ram_we)
  );

  // fill pattern for unwritten bytes from every address bit
  function automatic byte_t fill_byte(mcu_addr_t a);
    return a[23:16] ^ a[15:8] ^ a[7:0] ^ 8'h5a;
  endfunction

  function automatic byte_t rom_byte(mcu_addr_t a);
    if (rom_mem.exists(a)) return rom_mem[a];
    return fill_byte(a);
  endfunction

  function automatic byte_t ram_byte(ram_addr_t a);
    if (ram_mem.exists(a)) return ram_mem[a];
    return fill_byte({RAM_WINDOW_TAG, a});
  endfunction

  function automatic byte_t expect_byte(mcu_addr_t a);
    if (ref_mem.exists(a)) return ref_mem[a];
    return fill_byte(a);
  endfunction

  function automatic mcu_addr_t rand_rom_addr();
    mcu_addr_t a;
    a = mcu_addr_t'($urandom);
    while (a[23:19] == RAM_WINDOW_TAG) begin
      a = mcu_addr_t'($urandom);   // stay out of the RAM window
    end
    return a;
  endfunction

  function automatic mcu_addr_t rand_ram_addr();
    return {RAM_WINDOW_TAG, ram_addr_t'($urandom)};
  endfunction

  task automatic report_mismatch(input string what);
    $display("MISMATCH at %0t ns: %s", $time, what);
    $display("TEST FAILED");
    $fatal(1, "check failed");
  endtask

  // ----------------------------------------------------------------------
  // MCU side tasks start and return on a falling edge
  // ----------------------------------------------------------------------
  task automatic mcu_access(input logic write, input mcu_addr_t a, input byte_t d,
                            input logic wake, output byte_t q);
    while (!mcu_rdy) @(negedge CLK2);
    cur_addr = a;
    mcu_addr = a;
    mcu_dout = d;
    mcu_wrq  = write;
    mcu_rrq  = !write;
    @(posedge CLK2);
    if (wake) begin
      strobe_base = strobe_cnt;
      console_run = 1'b1;   // console comes back mid access
    end
    @(negedge CLK2);
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    while (!mcu_rdy) @(negedge CLK2);
    q = mcu_din;
  endtask

  task automatic mcu_write(input mcu_addr_t a, input byte_t d);
    byte_t unused;
    mcu_access(1'b1, a, d, 1'b0, unused);
    ref_mem[a] = d;
  endtask

  task automatic mcu_read_check(input mcu_addr_t a, input logic wake);
    byte_t got;
    mcu_access(1'b0, a, 8'h00, wake, got);
    assert (got == expect_byte(a))
      else report_mismatch($sformatf("read %06h got %02h expected %02h",
                                     a, got, expect_byte(a)));
  endtask

  task automatic run_console(input logic run);
    @(posedge CLK2);
    strobe_base = strobe_cnt;
    console_run = run;
    @(negedge CLK2);
  endtask

  task automatic check_strobes(input int expected, input string what);
    @(posedge CLK2);
    assert (strobe_cnt - strobe_base == expected)
      else report_mismatch($sformatf("%s: %0d reset strobes, expected %0d",
                                     what, strobe_cnt - strobe_base, expected));
    @(negedge CLK2);
  endtask

  initial begin : clock_gen
    CLK2 = 1'b0;
    forever #2 CLK2 = ~CLK2;
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < MAX_CYCLES) begin
      @(posedge CLK2);
      cycle_cnt++;
    end
    $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "simulation timed out");
  end

  // console CPU clock with a random period of 8..14 per cycle
  initial begin : console_bus
    int phase_left;
    int period;
    int low_len;
    snes_cpu_clk  = 1'b0;
    snes_romsel_n = 1'b1;
    snes_addr_in  = '0;
    phase_left    = 0;
    low_len       = 4;
    forever begin
      @(negedge CLK2);
      if (!console_run) begin
        snes_cpu_clk = 1'b0;
        phase_left   = 0;
      end else if (phase_left > 0) begin
        phase_left = phase_left - 1;
      end else if (!snes_cpu_clk) begin
        period        = $urandom_range(14, 8);
        low_len       = period - period / 2;
        phase_left    = period / 2 - 1;
        snes_cpu_clk  = 1'b1;
        snes_romsel_n = ($urandom & 1) != 0;
        snes_addr_in  = mcu_addr_t'($urandom);
      end else begin
        snes_cpu_clk = 1'b0;
        phase_left   = low_len - 1;
      end
    end
  end

  // ----------------------------------------------------------------------
  // ROM and RAM models plus bus checks
  // ----------------------------------------------------------------------
  initial begin : mem_models
    rom_data_in = '0;
    ram_data_in = '0;
    strobe_cnt  = 0;
    forever begin
      @(negedge CLK2);
      if (snes_reset_strobe) strobe_cnt++;
      if (!rom_we) begin
        assert (rom_data_oe && (rom_bhe != rom_ble) && (rom_ble == !cur_addr[0]))
          else report_mismatch($sformatf("ROM write lanes bhe=%b ble=%b oe=%b at %06h",
                                         rom_bhe, rom_ble, rom_data_oe, cur_addr));
        if (!rom_bhe) rom_mem[{rom_addr, 1'b0}] = rom_data_out[15:8];   // even byte
        if (!rom_ble) rom_mem[{rom_addr, 1'b1}] = rom_data_out[7:0];
      end
      if (!ram_we) begin
        assert (ram_data_oe && (ram_addr == cur_addr[18:0]))
          else report_mismatch($sformatf("RAM write addr %05h oe=%b for %06h",
                                         ram_addr, ram_data_oe, cur_addr));
        ram_mem[ram_addr] = ram_data_out;
      end
      rom_data_in = {rom_byte({rom_addr, 1'b0}), rom_byte({rom_addr, 1'b1})};
      ram_data_in = ram_byte(ram_addr);
    end
  end

  initial begin : main
    mcu_addr_t a;
    int        ram_first;
    void'($urandom(99));
    reset       = 1'b1;
    mcu_rrq     = 1'b0;
    mcu_wrq     = 1'b0;
    mcu_addr    = '0;
    mcu_dout    = '0;
    cur_addr    = '0;
    console_run = 1'b0;
    strobe_base = 0;
    repeat (5) @(negedge CLK2);
    reset = 1'b0;
    @(negedge CLK2);

    // idle levels with the console clock low
    assert (mcu_rdy && rom_we && ram_we && rom_bhe && rom_ble)
      else report_mismatch("strobes or ready not idle after reset");
    assert (!rom_data_oe && !ram_data_oe && !snes_reset_strobe)
      else report_mismatch("output enable or reset strobe active after reset");

    // ROM writes then reads, console dead
    for (int i = 0; i < 60; i++) begin
      a = rand_rom_addr();
      mcu_write(a, byte_t'($urandom));
      written.push_back(a);
    end
    foreach (written[i]) mcu_read_check(written[i], 1'b0);

    // RAM window, console dead
    ram_first = written.size();
    for (int i = 0; i < 60; i++) begin
      a = rand_ram_addr();
      mcu_write(a, byte_t'($urandom));
      written.push_back(a);
    end
    for (int i = ram_first; i < written.size(); i++) begin
      mcu_read_check(written[i], 1'b0);
    end

    // mixed traffic against a running console
    run_console(1'b1);
    for (int i = 0; i < 80; i++) begin
      if ($urandom_range(1, 0) == 1) a = rand_ram_addr();
      else a = rand_rom_addr();
      if ($urandom_range(2, 0) == 0) begin
        mcu_write(a, byte_t'($urandom));
        written.push_back(a);
      end else begin
        if ($urandom_range(1, 0) == 1) a = written[$urandom_range(written.size() - 1, 0)];
        mcu_read_check(a, 1'b0);
      end
    end

    // dead console revives once
    run_console(1'b0);
    repeat (300) @(negedge CLK2);
    run_console(1'b1);
    repeat (400) @(negedge CLK2);
    check_strobes(1, "console revive");

    // revive in the middle of a RAM read
    run_console(1'b0);
    repeat (300) @(negedge CLK2);
    mcu_read_check(written[ram_first], 1'b1);
    check_strobes(1, "revive during RAM read");

    $display("TEST OK");
    $finish;
  end

endmodule : cart_mem_ctrl_tb

`default_nettype wire
